// File: Makefile
VERILATOR ?= verilator
TOP       ?= mem_subsystem_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/clint_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbar_config.svh"

module clint_timer (
	input  wire                 clock,
	input  wire                 reset,

	input  wire  [31:0]         addr,
	input  wire                 valid,
	output logic                ready,

	output logic [31:0]         rsp_data,
	output mem_pkg::resp_u      rsp_resp,
	output logic                rsp_valid
);

	import mem_pkg::*;

	logic [63:0] mtime;
	logic        live;

	wire [31:0] offset = addr - `XBAR_CLINT_BASE;
	wire        fire   = valid & ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			mtime     <= '0;
			live      <= 1'b0;
			rsp_valid <= 1'b0;
		end else begin
			mtime     <= mtime + 64'd1;
			live      <= 1'b1;
			rsp_valid <= fire;
		end
	end

	// The two halves are sampled separately, so a wrap between reads is visible.
	always_ff @(posedge clock) begin
		if (fire) begin
			case (offset)
				32'd0: begin
					rsp_data     <= mtime[31:0];
					rsp_resp.axi <= RESP_OKAY;
				end
				32'd4: begin
					rsp_data     <= mtime[63:32];
					rsp_resp.axi <= RESP_OKAY;
				end
				default: begin
					rsp_data     <= '0;
					rsp_resp.axi <= RESP_SLVERR;
				end
			endcase
		end
	end

	assign ready = live & ~rsp_valid;

endmodule

`default_nettype wire

// File: hw/icache_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbar_config.svh"

module icache_store (
	input  wire                 clock,
	input  wire                 reset,

	input  wire  [31:0]         req_addr,
	input  wire                 req_valid,
	output logic                req_ready,

	output logic [31:0]         rsp_data,
	output mem_pkg::resp_u      rsp_status,
	output logic                rsp_valid,

	input  wire  [31:0]         fill_addr,
	input  wire  [31:0]         fill_data,
	input  wire                 fill_valid,
	output logic                fill_ready
);

	localparam int LINES = `XBAR_ICACHE_LINES;
	localparam int IDX_W = $clog2(LINES);
	localparam int TAG_W = 30 - IDX_W;

	logic [31:0]      data_mem [LINES];
	logic [TAG_W-1:0] tag_mem [LINES];
	logic [LINES-1:0] line_valid;
	logic             live;
	logic             pending;
	logic             hit_q;

	wire [IDX_W-1:0] req_idx   = req_addr[IDX_W+1:2];
	wire [TAG_W-1:0] req_tag   = req_addr[31:IDX_W+2];
	wire [IDX_W-1:0] fill_idx  = fill_addr[IDX_W+1:2];
	wire [TAG_W-1:0] fill_tag  = fill_addr[31:IDX_W+2];
	wire             req_fire  = req_valid & req_ready;
	wire             fill_fire = fill_valid & fill_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			live       <= 1'b0;
			pending    <= 1'b0;
			line_valid <= '0;
		end else begin
			live    <= 1'b1;
			pending <= req_fire;   // The response follows one cycle after acceptance.
			if (fill_fire)
				line_valid[fill_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (req_fire) begin
			rsp_data <= data_mem[req_idx];
			hit_q    <= line_valid[req_idx] && (tag_mem[req_idx] == req_tag);
		end
		if (fill_fire) begin
			data_mem[fill_idx] <= fill_data;
			tag_mem[fill_idx]  <= fill_tag;
		end
	end

	assign req_ready  = live & ~pending;
	assign fill_ready = live & ~pending;   // Fills wait out any lookup in flight.
	assign rsp_valid  = pending;

	always_comb begin
		rsp_status.cache.miss  = ~hit_q;
		rsp_status.cache.spare = 1'b0;
	end

	// The crossbar only starts a fill after it has seen the lookup response.
	fill_after_lookup: assert property (@(posedge clock) disable iff (reset)
		pending |-> !fill_valid);

endmodule

`default_nettype wire

// File: hw/mem_pkg.sv
`default_nettype none

package mem_pkg;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} resp_e;

	// Status returned on a cache lookup.
	typedef struct packed {
		logic miss;   // Set when no valid line matches the tag.
		logic spare;
	} cache_status_s;

	// The lookup status shares the response wires, so the crossbar can route either one.
	typedef union packed {
		resp_e         axi;
		cache_status_s cache;
	} resp_u;

endpackage

`default_nettype wire

// File: hw/mem_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top (
	input  wire                 clock,
	input  wire                 reset,

	input  wire  [31:0]         ifu_araddr,
	input  wire                 ifu_arvalid,
	output wire                 ifu_arready,
	output wire  [63:0]         ifu_rdata,
	output wire mem_pkg::resp_u ifu_rresp,
	output wire                 ifu_rvalid,
	input  wire                 ifu_rready,

	input  wire  [31:0]         lsu_araddr,
	input  wire  [2:0]          lsu_arsize,
	input  wire                 lsu_arvalid,
	output wire                 lsu_arready,
	output wire  [63:0]         lsu_rdata,
	output wire mem_pkg::resp_u lsu_rresp,
	output wire                 lsu_rvalid,
	input  wire                 lsu_rready,
	input  wire  [31:0]         lsu_awaddr,
	input  wire  [2:0]          lsu_awsize,
	input  wire                 lsu_awvalid,
	output wire                 lsu_awready,
	input  wire  [63:0]         lsu_wdata,
	input  wire  [7:0]          lsu_wstrb,
	input  wire                 lsu_wvalid,
	output wire                 lsu_wready,
	output wire mem_pkg::resp_u lsu_bresp,
	output wire                 lsu_bvalid,
	input  wire                 lsu_bready,

	output wire  [31:0]         master_araddr,
	output wire  [2:0]          master_arsize,
	output wire                 master_arvalid,
	input  wire                 master_arready,
	input  wire  [63:0]         master_rdata,
	input  wire mem_pkg::resp_u master_rresp,
	input  wire                 master_rvalid,
	output wire                 master_rready,
	output wire  [31:0]         master_awaddr,
	output wire  [2:0]          master_awsize,
	output wire                 master_awvalid,
	input  wire                 master_awready,
	output wire  [63:0]         master_wdata,
	output wire  [7:0]          master_wstrb,
	output wire                 master_wvalid,
	input  wire                 master_wready,
	input  wire mem_pkg::resp_u master_bresp,
	input  wire                 master_bvalid,
	output wire                 master_bready
);

	import mem_pkg::*;

	wire [31:0] cache_req_addr;
	wire        cache_req_valid;
	wire        cache_req_ready;
	wire [31:0] cache_rsp_data;
	wire resp_u cache_rsp_status;
	wire        cache_rsp_valid;
	wire [31:0] fill_addr;
	wire [31:0] fill_data;
	wire        fill_valid;
	wire        fill_ready;
	wire [31:0] clint_addr;
	wire        clint_valid;
	wire        clint_ready;
	wire [31:0] clint_rsp_data;
	wire resp_u clint_rsp_resp;
	wire        clint_rsp_valid;

	// Every crossbar port shares its name with a top port or a local wire.
	mem_xbar xbar_i (.*);

	icache_store icache_i (
		.clock      (clock),
		.reset      (reset),
		.req_addr   (cache_req_addr),
		.req_valid  (cache_req_valid),
		.req_ready  (cache_req_ready),
		.rsp_data   (cache_rsp_data),
		.rsp_status (cache_rsp_status),
		.rsp_valid  (cache_rsp_valid),
		.fill_addr  (fill_addr),
		.fill_data  (fill_data),
		.fill_valid (fill_valid),
		.fill_ready (fill_ready)
	);

	clint_timer clint_i (
		.clock     (clock),
		.reset     (reset),
		.addr      (clint_addr),
		.valid     (clint_valid),
		.ready     (clint_ready),
		.rsp_data  (clint_rsp_data),
		.rsp_resp  (clint_rsp_resp),
		.rsp_valid (clint_rsp_valid)
	);

endmodule

`default_nettype wire

// File: hw/mem_xbar.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbar_config.svh"

module mem_xbar (
	input  wire                 clock,
	input  wire                 reset,

	input  wire  [31:0]         ifu_araddr,
	input  wire                 ifu_arvalid,
	output logic                ifu_arready,
	output logic [63:0]         ifu_rdata,
	output mem_pkg::resp_u      ifu_rresp,
	output logic                ifu_rvalid,
	input  wire                 ifu_rready,

	input  wire  [31:0]         lsu_araddr,
	input  wire  [2:0]          lsu_arsize,
	input  wire                 lsu_arvalid,
	output logic                lsu_arready,
	output logic [63:0]         lsu_rdata,
	output mem_pkg::resp_u      lsu_rresp,
	output logic                lsu_rvalid,
	input  wire                 lsu_rready,

	input  wire  [31:0]         lsu_awaddr,
	input  wire  [2:0]          lsu_awsize,
	input  wire                 lsu_awvalid,
	output logic                lsu_awready,
	input  wire  [63:0]         lsu_wdata,
	input  wire  [7:0]          lsu_wstrb,
	input  wire                 lsu_wvalid,
	output logic                lsu_wready,
	output mem_pkg::resp_u      lsu_bresp,
	output logic                lsu_bvalid,
	input  wire                 lsu_bready,

	output logic [31:0]         master_araddr,
	output logic [2:0]          master_arsize,
	output logic                master_arvalid,
	input  wire                 master_arready,
	input  wire  [63:0]         master_rdata,
	input  wire mem_pkg::resp_u master_rresp,
	input  wire                 master_rvalid,
	output logic                master_rready,
	output logic [31:0]         master_awaddr,
	output logic [2:0]          master_awsize,
	output logic                master_awvalid,
	input  wire                 master_awready,
	output logic [63:0]         master_wdata,
	output logic [7:0]          master_wstrb,
	output logic                master_wvalid,
	input  wire                 master_wready,
	input  wire mem_pkg::resp_u master_bresp,
	input  wire                 master_bvalid,
	output logic                master_bready,

	output logic [31:0]         cache_req_addr,
	output logic                cache_req_valid,
	input  wire                 cache_req_ready,
	input  wire  [31:0]         cache_rsp_data,
	input  wire mem_pkg::resp_u cache_rsp_status,
	input  wire                 cache_rsp_valid,
	output logic [31:0]         fill_addr,
	output logic [31:0]         fill_data,
	output logic                fill_valid,
	input  wire                 fill_ready,

	output logic [31:0]         clint_addr,
	output logic                clint_valid,
	input  wire                 clint_ready,
	input  wire  [31:0]         clint_rsp_data,
	input  wire mem_pkg::resp_u clint_rsp_resp,
	input  wire                 clint_rsp_valid
);

	import mem_pkg::*;

	localparam logic [2:0] S_IDLE         = 3'd0;
	localparam logic [2:0] S_FETCH_LOOKUP = 3'd1;
	localparam logic [2:0] S_FETCH_MASTER = 3'd2;
	localparam logic [2:0] S_FILL         = 3'd3;
	localparam logic [2:0] S_FETCH_REPLY  = 3'd4;
	localparam logic [2:0] S_LOAD_READ    = 3'd5;
	localparam logic [2:0] S_LOAD_REPLY   = 3'd6;

	logic [2:0]  state;
	logic [2:0]  state_d;
	logic [31:0] req_addr;
	logic [2:0]  req_size;
	logic [63:0] data_q;
	resp_u       resp_q;
	logic        sent;

	function automatic logic in_window(input logic [31:0] addr, input logic [31:0] base,
			input logic [31:0] limit);
		return (addr >= base) && (addr <= limit);
	endfunction

	wire ifu_fire      = ifu_arvalid & ifu_arready;
	wire lsu_fire      = lsu_arvalid & lsu_arready;
	wire fetch_sram    = in_window(ifu_araddr, `XBAR_SRAM_BASE, `XBAR_SRAM_LIMIT);
	wire held_sram     = in_window(req_addr, `XBAR_SRAM_BASE, `XBAR_SRAM_LIMIT);
	wire held_clint    = in_window(req_addr, `XBAR_CLINT_BASE, `XBAR_CLINT_LIMIT);
	wire master_phase  = (state == S_FETCH_MASTER) | ((state == S_LOAD_READ) & ~held_clint);
	wire master_r_fire = master_rvalid & master_rready;
	wire sub_fire      = (cache_req_valid & cache_req_ready) | (master_arvalid & master_arready)
		| (clint_valid & clint_ready);

	always_comb begin
		state_d = state;
		case (state)
			S_IDLE: begin
				if (ifu_fire)
					state_d = fetch_sram ? S_FETCH_MASTER : S_FETCH_LOOKUP;
				else if (lsu_fire)
					state_d = S_LOAD_READ;
			end
			S_FETCH_LOOKUP:
				if (cache_rsp_valid)
					state_d = cache_rsp_status.cache.miss ? S_FETCH_MASTER : S_FETCH_REPLY;
			S_FETCH_MASTER:
				if (master_r_fire)
					state_d = held_sram ? S_FETCH_REPLY : S_FILL;
			S_FILL:
				if (fill_ready)
					state_d = S_FETCH_REPLY;
			S_FETCH_REPLY:
				if (ifu_rready)
					state_d = S_IDLE;
			S_LOAD_READ:
				if (held_clint ? clint_rsp_valid : master_r_fire)
					state_d = S_LOAD_REPLY;
			S_LOAD_REPLY:
				if (lsu_rready)
					state_d = S_IDLE;
			default:
				state_d = S_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= S_IDLE;
			sent        <= 1'b0;
			ifu_arready <= 1'b0;
			lsu_arready <= 1'b0;
		end else begin
			state <= state_d;
			if (state_d != state)
				sent <= 1'b0;   // Each state issues at most one downstream request.
			else if (sub_fire)
				sent <= 1'b1;
			if (ifu_fire)
				ifu_arready <= 1'b0;
			else if (state == S_IDLE && ifu_arvalid && !lsu_arready)
				ifu_arready <= 1'b1;
			if (lsu_fire)
				lsu_arready <= 1'b0;
			else if (state == S_IDLE && lsu_arvalid && !ifu_arvalid && !ifu_arready)
				lsu_arready <= 1'b1;   // Fetch requests win a tie.
		end
	end

	always_ff @(posedge clock) begin
		if (ifu_fire) begin
			req_addr <= ifu_araddr;
			req_size <= 3'b010;   // Instruction words are always 4 bytes.
		end else if (lsu_fire) begin
			req_addr <= lsu_araddr;
			req_size <= lsu_arsize;
		end
		if (state == S_FETCH_LOOKUP && cache_rsp_valid) begin
			data_q     <= {32'h0, cache_rsp_data};
			resp_q.axi <= RESP_OKAY;
		end
		if (master_r_fire) begin
			// Cached fetches only keep the low word, so a miss replies like a later hit.
			if (state == S_FETCH_MASTER && !held_sram)
				data_q <= {32'h0, master_rdata[31:0]};
			else
				data_q <= master_rdata;
			resp_q <= master_rresp;
		end
		if (state == S_LOAD_READ && held_clint && clint_rsp_valid) begin
			data_q <= {32'h0, clint_rsp_data};
			resp_q <= clint_rsp_resp;
		end
	end

	assign cache_req_addr  = req_addr;
	assign cache_req_valid = (state == S_FETCH_LOOKUP) & ~sent;
	assign fill_addr       = req_addr;
	assign fill_data       = data_q[31:0];
	assign fill_valid      = (state == S_FILL);
	assign clint_addr      = req_addr;
	assign clint_valid     = (state == S_LOAD_READ) & held_clint & ~sent;

	assign master_araddr  = req_addr;
	assign master_arsize  = req_size;
	assign master_arvalid = master_phase & ~sent;
	assign master_rready  = master_phase & sent;

	assign ifu_rdata  = data_q;
	assign ifu_rresp  = resp_q;
	assign ifu_rvalid = (state == S_FETCH_REPLY);
	assign lsu_rdata  = data_q;
	assign lsu_rresp  = resp_q;
	assign lsu_rvalid = (state == S_LOAD_REPLY);

	// Stores bypass the read machine entirely.
	assign master_awaddr  = lsu_awaddr;
	assign master_awsize  = lsu_awsize;
	assign master_awvalid = lsu_awvalid;
	assign lsu_awready    = master_awready;
	assign master_wdata   = lsu_wdata;
	assign master_wstrb   = lsu_wstrb;
	assign master_wvalid  = lsu_wvalid;
	assign lsu_wready     = master_wready;
	assign lsu_bresp      = master_bresp;
	assign lsu_bvalid     = master_bvalid;
	assign master_bready  = lsu_bready;

	ifu_reply_held: assert property (@(posedge clock) disable iff (reset)
		ifu_rvalid && !ifu_rready |=> ifu_rvalid && $stable(ifu_rdata));

	// The timer answers in the next cycle and the master port stays quiet meanwhile.
	clint_no_master: assert property (@(posedge clock) disable iff (reset)
		clint_valid && clint_ready |=> clint_rsp_valid && !master_arvalid);

endmodule

`default_nettype wire

// File: include/xbar_config.svh
`ifndef XBAR_CONFIG_SVH
`define XBAR_CONFIG_SVH

// Both address windows are inclusive of their limit.
`define XBAR_SRAM_BASE    32'h0f00_0000
`define XBAR_SRAM_LIMIT   32'h0f00_1fff

`define XBAR_CLINT_BASE   32'h0200_0000
`define XBAR_CLINT_LIMIT  32'h0200_ffff

// Lines hold one 32-bit word each and their number must be a power of two.
`define XBAR_ICACHE_LINES 16

`endif

// File: sim/mem_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbar_config.svh"

module mem_subsystem_tb;

	import mem_pkg::*;

	localparam int          N_OPS     = 300;
	localparam int          TIMEOUT   = 200 * N_OPS;
	localparam int          LINES     = `XBAR_ICACHE_LINES;
	localparam logic [31:0] CODE_BASE = 32'h0000_1000;
	localparam logic [31:0] DATA_BASE = 32'h8000_0000;

	wire         clock;
	wire         reset;

	logic [31:0] ifu_araddr;
	logic        ifu_arvalid;
	wire         ifu_arready;
	wire  [63:0] ifu_rdata;
	wire  [1:0]  ifu_rresp;
	wire         ifu_rvalid;
	logic        ifu_rready;

	logic [31:0] lsu_araddr;
	logic [2:0]  lsu_arsize;
	logic        lsu_arvalid;
	wire         lsu_arready;
	wire  [63:0] lsu_rdata;
	wire  [1:0]  lsu_rresp;
	wire         lsu_rvalid;
	logic        lsu_rready;
	logic [31:0] lsu_awaddr;
	logic [2:0]  lsu_awsize;
	logic        lsu_awvalid;
	wire         lsu_awready;
	logic [63:0] lsu_wdata;
	logic [7:0]  lsu_wstrb;
	logic        lsu_wvalid;
	wire         lsu_wready;
	wire  [1:0]  lsu_bresp;
	wire         lsu_bvalid;
	logic        lsu_bready;

	wire  [31:0] master_araddr;
	wire  [2:0]  master_arsize;
	wire         master_arvalid;
	wire         master_arready;
	wire  [63:0] master_rdata;
	wire  [1:0]  master_rresp;
	wire         master_rvalid;
	wire         master_rready;
	wire  [31:0] master_awaddr;
	wire  [2:0]  master_awsize;
	wire         master_awvalid;
	wire         master_awready;
	wire  [63:0] master_wdata;
	wire  [7:0]  master_wstrb;
	wire         master_wvalid;
	wire         master_wready;
	wire  [1:0]  master_bresp;
	wire         master_bvalid;
	wire         master_bready;
	wire  [31:0] master_reads;

	int          value_errors = 0;
	int          other_errors = 0;
	int          cycles = 0;
	logic [63:0] shadow [logic [31:0]];
	logic [31:0] line_addr [LINES];
	logic        line_valid [LINES];
	logic [31:0] last_mtime;
	logic        mtime_seen;
	logic [31:0] exp_ar_addr [$];
	logic [2:0]  exp_ar_size [$];

	tb_clock_gen clock_i (
		.clock (clock),
		.reset (reset)
	);

	mem_subsystem_top dut_i (.*);

	soc_mem_model mem_i (
		.clock      (clock),
		.reset      (reset),
		.araddr     (master_araddr),
		.arvalid    (master_arvalid),
		.arready    (master_arready),
		.rdata      (master_rdata),
		.rresp      (master_rresp),
		.rvalid     (master_rvalid),
		.rready     (master_rready),
		.awaddr     (master_awaddr),
		.awvalid    (master_awvalid),
		.awready    (master_awready),
		.wdata      (master_wdata),
		.wstrb      (master_wstrb),
		.wvalid     (master_wvalid),
		.wready     (master_wready),
		.bresp      (master_bresp),
		.bvalid     (master_bvalid),
		.bready     (master_bready),
		.read_count (master_reads)
	);

	always @(posedge clock) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
			$display("Test failed");
			$finish;
		end
	end

	task automatic check(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("At %0t: %s", $time, what);
		other_errors++;
	endtask

	// Each read on the master port must match the next one the model expects.
	always @(negedge clock) begin
		logic [31:0] want_addr;
		logic [2:0]  want_size;
		if (!reset && master_arvalid && master_arready) begin
			if (exp_ar_addr.size() == 0) begin
				report_failure("master read issued while none was expected");
			end else begin
				want_addr = exp_ar_addr.pop_front();
				want_size = exp_ar_size.pop_front();
				check("master_araddr", 64'(want_addr), 64'(master_araddr));
				check("master_arsize", 64'(want_size), 64'(master_arsize));
			end
		end
	end

	function automatic logic [63:0] word_at(input logic [31:0] addr);
		logic [31:0] key;
		key = {addr[31:2], 2'b00};
		if (shadow.exists(key))
			return shadow[key];
		return {32'h0, key ^ 32'ha5a5a5a5};
	endfunction

	// Models the direct-mapped cache by word address and updates the tag copy on a miss.
	task automatic expect_fetch(input logic [31:0] addr, output logic [63:0] data,
			output int reads);
		int          idx;
		logic [63:0] word;
		word = word_at(addr);
		if (addr >= `XBAR_SRAM_BASE && addr <= `XBAR_SRAM_LIMIT) begin
			data  = word;
			reads = 1;
		end else begin
			idx             = int'((addr >> 2) % LINES);
			reads           = (line_valid[idx] && line_addr[idx] == addr) ? 0 : 1;
			line_valid[idx] = 1'b1;
			line_addr[idx]  = addr;
			data            = {32'h0, word[31:0]};
		end
	endtask

	task automatic ifu_read(input logic [31:0] addr, output logic [63:0] data,
			output logic [1:0] resp, output time done_at);
		int hold;
		ifu_araddr  = addr;
		ifu_arvalid = 1'b1;
		do
			@(negedge clock);
		while (!ifu_arready);
		@(posedge clock);
		#1 ifu_arvalid = 1'b0;
		do
			@(negedge clock);
		while (!ifu_rvalid);
		data = ifu_rdata;
		resp = ifu_rresp;
		hold = $urandom_range(0, 3);
		repeat (hold) begin
			@(negedge clock);
			check("ifu_rvalid", 64'd1, 64'(ifu_rvalid));
			check("ifu_rdata", data, ifu_rdata);
		end
		@(posedge clock);
		#1 ifu_rready = 1'b1;
		@(posedge clock);
		done_at = $time;
		#1 ifu_rready = 1'b0;
	endtask

	task automatic lsu_read(input logic [31:0] addr, input logic [2:0] size,
			output logic [63:0] data, output logic [1:0] resp, output time done_at);
		int hold;
		lsu_araddr  = addr;
		lsu_arsize  = size;
		lsu_arvalid = 1'b1;
		do
			@(negedge clock);
		while (!lsu_arready);
		@(posedge clock);
		#1 lsu_arvalid = 1'b0;
		do
			@(negedge clock);
		while (!lsu_rvalid);
		data = lsu_rdata;
		resp = lsu_rresp;
		hold = $urandom_range(0, 3);
		repeat (hold) begin
			@(negedge clock);
			check("lsu_rvalid", 64'd1, 64'(lsu_rvalid));
			check("lsu_rdata", data, lsu_rdata);
		end
		@(posedge clock);
		#1 lsu_rready = 1'b1;
		@(posedge clock);
		done_at = $time;
		#1 lsu_rready = 1'b0;
	endtask

	task automatic lsu_write(input logic [31:0] addr, input logic [63:0] data,
			input logic [7:0] strb, output logic [1:0] resp);
		logic aw_seen;
		logic w_seen;
		logic aw_done;
		logic w_done;
		lsu_awaddr  = addr;
		lsu_awsize  = 3'd3;
		lsu_awvalid = 1'b1;
		lsu_wdata   = data;
		lsu_wstrb   = strb;
		lsu_wvalid  = 1'b1;
		aw_done     = 1'b0;
		w_done      = 1'b0;
		while (!(aw_done && w_done)) begin
			@(negedge clock);
			aw_seen = lsu_awvalid && lsu_awready;
			w_seen  = lsu_wvalid && lsu_wready;
			if (aw_seen) begin
				check("master_awaddr", 64'(addr), 64'(master_awaddr));
				check("master_awsize", 64'd3, 64'(master_awsize));
			end
			if (w_seen) begin
				check("master_wdata", data, master_wdata);
				check("master_wstrb", 64'(strb), 64'(master_wstrb));
			end
			@(posedge clock);
			#1;
			if (aw_seen) begin
				lsu_awvalid = 1'b0;
				aw_done     = 1'b1;
			end
			if (w_seen) begin
				lsu_wvalid = 1'b0;
				w_done     = 1'b1;
			end
		end
		do
			@(negedge clock);
		while (!lsu_bvalid);
		resp = lsu_bresp;
		@(posedge clock);
		#1 lsu_bready = 1'b1;
		@(posedge clock);
		#1 lsu_bready = 1'b0;
	endtask

	task automatic do_fetch(input logic [31:0] addr);
		logic [63:0] exp_data;
		logic [63:0] data;
		logic [1:0]  resp;
		logic [31:0] reads_before;
		int          exp_reads;
		time         done_at;
		expect_fetch(addr, exp_data, exp_reads);
		if (exp_reads == 1) begin
			exp_ar_addr.push_back(addr);
			exp_ar_size.push_back(3'd2);
		end
		reads_before = master_reads;
		ifu_read(addr, data, resp, done_at);
		check("ifu_rdata", exp_data, data);
		check("ifu_rresp", 64'(RESP_OKAY), 64'(resp));
		check("master_reads", 64'(reads_before + exp_reads), 64'(master_reads));
	endtask

	task automatic do_store(input logic [31:0] addr);
		logic [63:0] data;
		logic [63:0] word;
		logic [7:0]  strb;
		logic [1:0]  resp;
		int          i;
		data = {$urandom(), $urandom()};
		strb = 8'($urandom());
		lsu_write(addr, data, strb, resp);
		check("lsu_bresp", 64'(RESP_OKAY), 64'(resp));
		word = word_at(addr);
		for (i = 0; i < 8; i++)
			if (strb[i])
				word[8*i +: 8] = data[8*i +: 8];
		shadow[{addr[31:2], 2'b00}] = word;
	endtask

	task automatic do_load(input logic [31:0] addr);
		logic [63:0] data;
		logic [1:0]  resp;
		logic [31:0] reads_before;
		time         done_at;
		reads_before = master_reads;
		exp_ar_addr.push_back(addr);
		exp_ar_size.push_back(3'd3);
		lsu_read(addr, 3'd3, data, resp, done_at);
		check("lsu_rdata", word_at(addr), data);
		check("lsu_rresp", 64'(RESP_OKAY), 64'(resp));
		check("master_reads", 64'(reads_before + 32'd1), 64'(master_reads));
	endtask

	task automatic do_clint(input logic [31:0] offset);
		logic [63:0] data;
		logic [1:0]  resp;
		logic [31:0] reads_before;
		time         done_at;
		reads_before = master_reads;
		lsu_read(`XBAR_CLINT_BASE + offset, 3'd2, data, resp, done_at);
		check("master_reads", 64'(reads_before), 64'(master_reads));
		if (offset == 32'd0) begin
			check("lsu_rresp", 64'(RESP_OKAY), 64'(resp));
			check("lsu_rdata_high", 64'd0, 64'(data[63:32]));
			if (mtime_seen && data[31:0] < last_mtime)
				report_failure("mtime low word went backwards between two reads");
			last_mtime = data[31:0];
			mtime_seen = 1'b1;
		end else if (offset == 32'd4) begin
			// The run is far shorter than 2**32 cycles, so the high word is still zero.
			check("lsu_rdata", 64'd0, data);
			check("lsu_rresp", 64'(RESP_OKAY), 64'(resp));
		end else begin
			check("lsu_rdata", 64'd0, data);
			check("lsu_rresp", 64'(RESP_SLVERR), 64'(resp));
		end
	endtask

	task automatic do_dual(input logic [31:0] fetch_addr, input logic [31:0] load_addr);
		logic [63:0] exp_fetch;
		logic [63:0] exp_load;
		logic [63:0] fetch_data;
		logic [63:0] load_data;
		logic [1:0]  fetch_resp;
		logic [1:0]  load_resp;
		logic [31:0] reads_before;
		int          fetch_reads;
		time         fetch_done;
		time         load_done;
		expect_fetch(fetch_addr, exp_fetch, fetch_reads);
		exp_load     = word_at(load_addr);
		reads_before = master_reads;
		if (fetch_reads == 1) begin
			exp_ar_addr.push_back(fetch_addr);
			exp_ar_size.push_back(3'd2);
		end
		exp_ar_addr.push_back(load_addr);
		exp_ar_size.push_back(3'd3);
		fork
			ifu_read(fetch_addr, fetch_data, fetch_resp, fetch_done);
			lsu_read(load_addr, 3'd3, load_data, load_resp, load_done);
		join
		check("ifu_rdata", exp_fetch, fetch_data);
		check("ifu_rresp", 64'(RESP_OKAY), 64'(fetch_resp));
		check("lsu_rdata", exp_load, load_data);
		check("lsu_rresp", 64'(RESP_OKAY), 64'(load_resp));
		check("master_reads", 64'(reads_before + fetch_reads + 1), 64'(master_reads));
		if (fetch_done >= load_done)
			report_failure("load was served before a fetch that asked in the same cycle");
	endtask

	initial begin
		int n;
		int kind;
		int sel;
		void'($urandom(32'h735a));
		ifu_araddr  = '0;
		ifu_arvalid = 1'b0;
		ifu_rready  = 1'b0;
		lsu_araddr  = '0;
		lsu_arsize  = '0;
		lsu_arvalid = 1'b0;
		lsu_rready  = 1'b0;
		lsu_awaddr  = '0;
		lsu_awsize  = '0;
		lsu_awvalid = 1'b0;
		lsu_wdata   = '0;
		lsu_wstrb   = '0;
		lsu_wvalid  = 1'b0;
		lsu_bready  = 1'b0;
		mtime_seen  = 1'b0;
		last_mtime  = '0;
		for (n = 0; n < LINES; n++)
			line_valid[n] = 1'b0;

		@(negedge reset);
		@(posedge clock);
		#1;
		check("ifu_arready", 64'd0, 64'(ifu_arready));
		check("lsu_arready", 64'd0, 64'(lsu_arready));
		check("ifu_rvalid", 64'd0, 64'(ifu_rvalid));
		check("lsu_rvalid", 64'd0, 64'(lsu_rvalid));
		check("master_arvalid", 64'd0, 64'(master_arvalid));

		for (n = 0; n < N_OPS; n++) begin
			kind = $urandom_range(0, 9);
			case (kind)
				0, 1: do_fetch(`XBAR_SRAM_BASE + 32'd4 * $urandom_range(0, 2047));
				2, 3, 4: do_fetch(CODE_BASE + 32'd4 * $urandom_range(0, 47));   // Three tags per line.
				5, 6: do_store(DATA_BASE + 32'd4 * $urandom_range(0, 15));
				7: do_load(DATA_BASE + 32'd4 * $urandom_range(0, 15));
				8: begin
					sel = $urandom_range(0, 3);
					do_clint(sel < 2 ? 32'd0 : (sel == 2 ? 32'd4 : 32'd8));
				end
				default: begin
					if ($urandom_range(0, 1) == 0)
						do_dual(CODE_BASE + 32'd4 * $urandom_range(0, 47),
							DATA_BASE + 32'd4 * $urandom_range(0, 15));
					else
						do_dual(`XBAR_SRAM_BASE + 32'd4 * $urandom_range(0, 2047),
							DATA_BASE + 32'd4 * $urandom_range(0, 15));
				end
			endcase
		end

		$display("Errors: %0d value mismatches, %0d other failures", value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/soc_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module soc_mem_model (
	input  wire         clock,
	input  wire         reset,

	input  wire  [31:0] araddr,
	input  wire         arvalid,
	output logic        arready,
	output logic [63:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  wire         rready,

	input  wire  [31:0] awaddr,
	input  wire         awvalid,
	output logic        awready,
	input  wire  [63:0] wdata,
	input  wire  [7:0]  wstrb,
	input  wire         wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  wire         bready,

	output logic [31:0] read_count
);

	logic [63:0] mem [logic [31:0]];

	// Words never written read back as a pattern built from their own address.
	function automatic logic [63:0] load_word(input logic [31:0] addr);
		logic [31:0] key;
		key = {addr[31:2], 2'b00};
		if (mem.exists(key))
			return mem[key];
		return {32'h0, key ^ 32'ha5a5a5a5};
	endfunction

	task automatic pause(input int n);
		repeat (n) begin
			@(posedge clock);
			#1;
		end
	endtask

	initial begin
		logic [31:0] addr;
		arready    = 1'b0;
		rvalid     = 1'b0;
		rdata      = '0;
		rresp      = '0;
		read_count = '0;
		forever begin
			@(negedge clock);
			if (!reset && arvalid) begin
				addr = araddr;
				pause($urandom_range(0, 3) + 1);
				arready = 1'b1;
				pause(1);   // The request is held, so it is taken on this edge.
				arready    = 1'b0;
				read_count = read_count + 32'd1;
				pause($urandom_range(0, 3));
				rdata  = load_word(addr);
				rresp  = 2'b00;
				rvalid = 1'b1;
				do
					@(negedge clock);
				while (!rready);
				pause(1);
				rvalid = 1'b0;
			end
		end
	end

	initial begin
		logic [31:0] key;
		logic [63:0] word;
		logic [63:0] data;
		logic [7:0]  strb;
		int          i;
		awready = 1'b0;
		wready  = 1'b0;
		bvalid  = 1'b0;
		bresp   = '0;
		forever begin
			@(negedge clock);
			if (!reset && awvalid) begin
				key = {awaddr[31:2], 2'b00};
				pause($urandom_range(0, 3) + 1);
				awready = 1'b1;
				pause(1);
				awready = 1'b0;
				do
					@(negedge clock);
				while (!wvalid);
				data = wdata;
				strb = wstrb;
				pause($urandom_range(0, 3) + 1);
				wready = 1'b1;
				pause(1);
				wready = 1'b0;
				word = load_word(key);
				for (i = 0; i < 8; i++)
					if (strb[i])
						word[8*i +: 8] = data[8*i +: 8];
				mem[key] = word;
				pause($urandom_range(0, 3));
				bresp  = 2'b00;
				bvalid = 1'b1;
				do
					@(negedge clock);
				while (!bready);
				pause(1);
				bvalid = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clock);
		#1 reset = 1'b0;   // Released just after the second rising edge.
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
hw/mem_pkg.sv
hw/icache_store.sv
hw/clint_timer.sv
hw/mem_xbar.sv
hw/mem_subsystem_top.sv
sim/tb_clock_gen.sv
sim/soc_mem_model.sv
sim/mem_subsystem_tb.sv
